// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_core -o sim_core

run: compile
	./obj_dir/sim_core | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: common/rv_consts.svh
// Core-wide widths, reset address and NOP encoding macros
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width, 32 integer registers
`define RV_REG_ADDR_W 5

// Default fetch address after reset
`define RV_RESET_ADDR 32'h8000_0000

// ADDI x0, x0, 0 fills flushed slots
`define RV_NOP 32'h0000_0013

`endif

// File: common/rv_isa_pkg.sv
// RV32I encoding types: opcodes, funct3 codes, ALU and branch operation codes
package rv_isa_pkg;

    localparam int unsigned NUM_REGS = 32;  // x0..x31, x0 hardwired

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_SR = 3'b101;  // SRL/SRA share it, funct7 bit 5 splits

    // funct7[5] joined to funct3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

endpackage

// File: common/rv_pipe_pkg.sv
// Pipeline datapath types: data word, register index, forwarding select
`include "rv_consts.svh"

package rv_pipe_pkg;

    // Data and address word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Operand source in execute
    typedef enum logic {
        FWD_REG = 1'b0,  // Value read in decode
        FWD_WB  = 1'b1   // Execute/writeback result
    } fwd_sel_e;

endpackage

// File: decode/rv_decode.sv
// Decode stage: field extraction, immediates, control and decode/execute register
module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_i,
    input  logic      flush_i,
    input  word_t     if_instr_i,
    input  word_t     if_pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output word_t     ex_pc_o,
    output alu_op_e   ex_op_o,
    output funct3_t   ex_funct3_o,
    output reg_addr_t ex_rd_o,
    output logic      ex_reg_we_o,
    output logic      ex_branch_o,
    output word_t     ex_opa_o,
    output word_t     ex_opb_o,
    output word_t     ex_rs2_val_o,
    output reg_addr_t ex_rs1_idx_o,
    output reg_addr_t ex_rs2_idx_o,
    output logic      ex_opb_is_reg_o,
    output word_t     ex_imm_o,
    output logic      ex_valid_op_o
);

    opcode_e   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    logic      funct7_b5;
    word_t     imm_i, imm_b, imm_u, imm;
    logic      is_op, is_op_imm, is_lui, is_branch;
    logic      use_imm;
    alu_op_e   alu_op;

    assign opcode     = opcode_e'(if_instr_i[6:0]);
    assign rd         = if_instr_i[11:7];
    assign funct3     = if_instr_i[14:12];
    assign rs1_addr_o = if_instr_i[19:15];
    assign rs2_addr_o = if_instr_i[24:20];
    assign funct7_b5  = if_instr_i[30];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_b = {{20{if_instr_i[31]}}, if_instr_i[7], if_instr_i[30:25],
                    if_instr_i[11:8], 1'b0};
    assign imm_u = {if_instr_i[31:12], 12'b0};

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_branch = (opcode == OPC_BRANCH);
    assign use_imm   = is_op_imm || is_lui;

    assign imm = is_op_imm ? imm_i :
                 is_branch ? imm_b :
                 is_lui    ? imm_u : '0;

    always_comb begin
        case (opcode)
            OPC_OP:     alu_op = alu_op_e'({funct7_b5, funct3});
            // Bit 30 is immediate data except for shifts right
            OPC_OP_IMM: alu_op = alu_op_e'({(funct3 == F3_SR) & funct7_b5, funct3});
            default:    alu_op = ALU_ADD;  // LUI adds to zero
        endcase
    end

    // Control part of decode/execute, NOP on flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_we_o   <= 1'b0;
            ex_branch_o   <= 1'b0;
            ex_valid_op_o <= 1'b1;
        end else if (!stall_i) begin
            if (flush_i) begin
                ex_reg_we_o   <= 1'b0;
                ex_branch_o   <= 1'b0;
                ex_valid_op_o <= 1'b1;
            end else begin
                ex_reg_we_o   <= is_op || use_imm;
                ex_branch_o   <= is_branch;
                ex_valid_op_o <= is_op || use_imm || is_branch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_pc_o         <= if_pc_i;
            ex_op_o         <= alu_op;
            ex_funct3_o     <= funct3;
            ex_rd_o         <= rd;
            ex_opa_o        <= is_lui ? '0 : rs1_data_i;
            ex_opb_o        <= use_imm ? imm : rs2_data_i;
            ex_rs2_val_o    <= rs2_data_i;
            ex_rs1_idx_o    <= is_lui ? '0 : rs1_addr_o;  // No rs1 field in LUI
            ex_rs2_idx_o    <= rs2_addr_o;
            ex_opb_is_reg_o <= !use_imm;
            ex_imm_o        <= imm;
        end
    end

endmodule

// File: decode/rv_regfile_wb.sv
// Register file with write-through reads, written from writeback, and retire outputs
module rv_regfile_wb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t regs [1:NUM_REGS-1];  // x0 is not stored
    logic  wr_en;

    assign wr_en = wb_we_i && (wb_rd_i != '0) && !stall_i;

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && addr == wb_rd_i) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Retirement seen at the write port
    assign wb_valid_o = wr_en;
    assign wb_rd_o    = wb_rd_i;
    assign wb_data_o  = wb_data_i;

    // Stored value is visible the cycle after the write
    a_read_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        $past(wr_en) && rs1_addr_i == $past(wb_rd_i) && !(wr_en && wb_rd_i == rs1_addr_i)
        |-> rs1_data_o == $past(wb_data_i))
        else $error("Register x%0d lost its write", rs1_addr_i);

endmodule

// File: src.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
verilog/rv_fetch.sv
decode/rv_decode.sv
decode/rv_regfile_wb.sv
verilog/rv_execute.sv
verilog/rv_core_top.sv
verif/tb_core.sv

// File: verif/tb_core.sv
// Testbench for the four-stage core: clock, memory model, reference interpreter, checks
`include "rv_consts.svh"

module tb_core;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst_n;
    logic        instr_ready;
    logic [31:0] instr_data;
    logic [31:0] instr_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        error;

    logic [31:0] imem [0:255];
    int          prog_len;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    bit          ready_pat [$];
    bit          expect_err;
    logic [31:0] rng_state = 32'hb167;
    int          errors;
    int          tests_failed;

    rv_core_top uut (
        .clk(clk), .rst_n(rst_n), .instr_ready_i(instr_ready), .instr_data_i(instr_data),
        .instr_addr_o(instr_addr), .wb_valid_o(wb_valid), .wb_rd_o(wb_rd),
        .wb_data_o(wb_data), .error_o(error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Combinational memory, NOP outside the program window
    always_comb begin
        logic [31:0] offs;
        offs = instr_addr - `RV_RESET_ADDR;
        instr_data = (offs < 32'd1024) ? imem[offs[9:2]] : `RV_NOP;
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] o, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA-level interpreter, fills the expected retirement list
    function automatic void compute_expected();
        logic [31:0] rf [32];
        logic [31:0] ins, res, immb;
        logic [31:0] a, b;
        logic [2:0]  f3;
        bit          wr, tk;
        int          pc;
        int          steps;
        pc = 0;
        steps = 0;
        expect_err = 0;
        foreach (rf[k]) rf[k] = 32'b0;
        while (pc >= 0 && pc < prog_len && steps < 1000) begin
            ins = imem[pc];
            f3 = ins[14:12];
            a = rf[ins[19:15]];
            b = rf[ins[24:20]];
            wr = 0;
            tk = 0;
            res = 32'b0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1;
                    res = ref_alu(f3, ins[30], a, b);
                end
                7'h13: begin
                    wr = 1;
                    res = ref_alu(f3, (f3 == 3'd5) && ins[30], a, {{20{ins[31]}}, ins[31:20]});
                end
                7'h37: begin
                    wr = 1;
                    res = {ins[31:12], 12'b0};
                end
                7'h63: begin
                    case (f3)
                        3'd0:    tk = (a == b);
                        3'd1:    tk = (a != b);
                        3'd4:    tk = ($signed(a) < $signed(b));
                        3'd5:    tk = ($signed(a) >= $signed(b));
                        3'd6:    tk = (a < b);
                        default: tk = (a >= b);
                    endcase
                end
                default: expect_err = 1;  // Unsupported opcode retires nothing
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                rf[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_val.push_back(res);
            end
            immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            pc = tk ? pc + $signed(immb) / 4 : pc + 1;
            steps++;
        end
    endfunction

    task automatic emit(logic [31:0] ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic clear_prog();
        foreach (imem[k]) imem[k] = `RV_NOP;
        prog_len = 0;
    endtask

    // Chain over x1..x8, every source is one of the two latest results
    task automatic build_chain();
        logic [31:0] r;
        logic [4:0]  p1, p2, rd, s1, s2;
        logic [11:0] imm;
        for (int k = 1; k <= 8; k++) begin
            r = xorshift();
            emit(enc_i(r[11:0], 5'd0, 3'd0, 5'(k)));
        end
        p1 = 5'd8;
        p2 = 5'd7;
        for (int k = 0; k < 24; k++) begin
            r = xorshift();
            rd = {2'b0, r[2:0]} + 5'd1;
            s1 = r[3] ? p1 : p2;
            s2 = r[3] ? p2 : p1;
            if (r[4]) begin
                emit(enc_r((r[7:5] == 3'd0 || r[7:5] == 3'd5) && r[8], s2, s1, r[7:5], rd));
            end else begin
                imm = r[31:20];
                if (r[7:5] == 3'd1 || r[7:5] == 3'd5) begin
                    imm = {1'b0, r[7:5] == 3'd5 && r[8], 5'b0, r[24:20]};
                end
                emit(enc_i(imm, s1, r[7:5], rd));
            end
            p2 = p1;
            p1 = rd;
        end
    endtask

    // Branch over one ADDI, then one ADDI that always runs
    task automatic branch_pair(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, int k);
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(12'(k), 5'd0, 3'd0, 5'(10 + k % 8)));
        emit(enc_i(12'(k + 100), 5'd0, 3'd0, 5'(20 + k % 8)));
    endtask

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd.size() == 0) begin
                $display("Unexpected retirement of x%0d at %0t", wb_rd, $time);
                errors++;
            end else begin
                assert (wb_rd == exp_rd[0] && wb_data == exp_val[0]) else begin
                    $display("CHECK FAILED at %0t: x%0d=%h, expected x%0d=%h", $time,
                             wb_rd, wb_data, exp_rd[0], exp_val[0]);
                    errors++;
                end
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    task automatic run_test(string name, bit random_ready);
        int errors_before;
        int low_cnt;
        int limit;
        int cycles;
        errors_before = errors;
        low_cnt = 0;
        ready_pat.delete();
        compute_expected();
        if (random_ready) begin
            for (int k = 0; k < prog_len * 8; k++) begin
                ready_pat.push_back(xorshift() % 4 != 0);
                low_cnt += ready_pat[k] ? 0 : 1;
            end
        end
        @(posedge clk);
        #1 rst_n = 1'b0;
        instr_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        limit = prog_len * 4 + low_cnt + 20;
        cycles = 0;
        while (exp_rd.size() > 0 && cycles < limit) begin
            @(posedge clk);
            #1 instr_ready = (cycles < ready_pat.size()) ? ready_pat[cycles] : 1'b1;
            cycles++;
        end
        if (exp_rd.size() > 0) begin
            $display("Timeout in %s: %0d results never retired", name, exp_rd.size());
            $display("Something failed");
            $finish;
        end
        instr_ready = 1'b1;
        for (int k = 0; k < 2; k++) begin
            repeat (6) @(posedge clk);
            @(negedge clk);
            assert (error == expect_err) else begin
                $display("CHECK FAILED at %0t: error_o=%b, expected %b", $time, error, expect_err);
                errors++;
            end
        end
        if (errors != errors_before) tests_failed++;
        $display("%s: %s", name, (errors == errors_before) ? "pass" : "FAIL");
    endtask

    initial begin
        logic [31:0] chain_seed;
        rst_n = 1'b0;
        instr_ready = 1'b1;
        errors = 0;
        tests_failed = 0;
        clear_prog();

        chain_seed = rng_state;
        build_chain();
        run_test("test 1 dependent chain", 1'b0);

        clear_prog();
        emit({20'h80001, 5'd1, 7'h37});
        emit(enc_i(12'h234, 5'd1, 3'd0, 5'd1));
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd2));
        emit(enc_r(1'b0, 5'd2, 5'd1, 3'd1, 5'd3));
        emit(enc_r(1'b0, 5'd2, 5'd1, 3'd5, 5'd4));
        emit(enc_r(1'b1, 5'd2, 5'd1, 3'd5, 5'd5));
        emit(enc_i(12'h407, 5'd1, 3'd5, 5'd6));  // SRAI by 7
        emit(enc_i(12'd31, 5'd1, 3'd5, 5'd7));
        emit(enc_r(1'b0, 5'd2, 5'd1, 3'd2, 5'd8));
        emit(enc_r(1'b0, 5'd2, 5'd1, 3'd3, 5'd9));
        emit(enc_r(1'b1, 5'd1, 5'd2, 3'd0, 5'd10));
        emit(enc_i(12'hfff, 5'd2, 3'd3, 5'd11));
        run_test("test 2 shifts and compares", 1'b0);

        clear_prog();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1));
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd2));
        emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd3));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd4));
        branch_pair(3'd0, 5'd1, 5'd2, 0);
        branch_pair(3'd0, 5'd1, 5'd4, 1);
        branch_pair(3'd1, 5'd1, 5'd4, 2);
        branch_pair(3'd1, 5'd1, 5'd2, 3);
        branch_pair(3'd4, 5'd3, 5'd4, 4);
        branch_pair(3'd4, 5'd4, 5'd3, 5);
        branch_pair(3'd5, 5'd4, 5'd3, 6);
        branch_pair(3'd5, 5'd3, 5'd4, 7);
        branch_pair(3'd5, 5'd1, 5'd2, 8);
        branch_pair(3'd6, 5'd4, 5'd3, 9);
        branch_pair(3'd6, 5'd3, 5'd4, 10);
        branch_pair(3'd7, 5'd3, 5'd4, 11);
        branch_pair(3'd7, 5'd4, 5'd3, 12);
        run_test("test 3 branches", 1'b0);

        clear_prog();
        rng_state = chain_seed;  // Same program as test 1
        build_chain();
        run_test("test 4 chain with stalls", 1'b1);

        clear_prog();
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd1));
        emit(enc_i(12'd55, 5'd1, 3'd0, 5'd0));
        emit(enc_r(1'b0, 5'd1, 5'd0, 3'd0, 5'd6));
        emit({20'h12345, 5'd0, 7'h37});
        emit(enc_i(12'd9, 5'd0, 3'd0, 5'd7));
        emit(enc_r(1'b0, 5'd0, 5'd0, 3'd6, 5'd8));
        run_test("test 5 x0 writes", 1'b0);

        clear_prog();
        emit(enc_i(12'd11, 5'd0, 3'd0, 5'd1));
        emit(enc_i(12'd4, 5'd1, 3'd0, 5'd2));
        emit({7'b0, 5'd2, 5'd1, 3'd2, 5'd0, 7'h23});  // SW x2, 0(x1)
        emit(enc_i(12'd1, 5'd2, 3'd0, 5'd3));
        run_test("test 6 unsupported opcode", 1'b0);

        $display("Tests run: 6, failed: %0d, check errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/rv_core_top.sv
// Four-stage RV32I core top level: fetch, decode, execute, writeback
`include "rv_consts.svh"

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter word_t RESET_ADDR = `RV_RESET_ADDR
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_ready_i,
    input  word_t     instr_data_i,
    output word_t     instr_addr_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      error_o
);

    logic      stall;
    logic      redirect, flush;
    word_t     target;
    word_t     if_instr, if_pc;
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    word_t     ex_pc, ex_opa, ex_opb, ex_rs2_val, ex_imm;
    alu_op_e   ex_op;
    funct3_t   ex_funct3;
    reg_addr_t ex_rd, ex_rs1_idx, ex_rs2_idx;
    logic      ex_reg_we, ex_branch, ex_opb_is_reg, ex_valid_op;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    assign stall = !instr_ready_i;  // Whole pipeline freezes

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .clk(clk), .rst_n(rst_n), .stall_i(stall),
        .redirect_i(redirect), .target_i(target), .flush_i(flush),
        .instr_data_i(instr_data_i), .instr_addr_o(instr_addr_o),
        .if_instr_o(if_instr), .if_pc_o(if_pc)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .stall_i(stall), .flush_i(flush),
        .if_instr_i(if_instr), .if_pc_i(if_pc),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .ex_pc_o(ex_pc), .ex_op_o(ex_op), .ex_funct3_o(ex_funct3), .ex_rd_o(ex_rd),
        .ex_reg_we_o(ex_reg_we), .ex_branch_o(ex_branch),
        .ex_opa_o(ex_opa), .ex_opb_o(ex_opb), .ex_rs2_val_o(ex_rs2_val),
        .ex_rs1_idx_o(ex_rs1_idx), .ex_rs2_idx_o(ex_rs2_idx),
        .ex_opb_is_reg_o(ex_opb_is_reg), .ex_imm_o(ex_imm), .ex_valid_op_o(ex_valid_op)
    );

    rv_regfile_wb u_regfile (
        .clk(clk), .rst_n(rst_n), .stall_i(stall),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .stall_i(stall),
        .ex_pc_i(ex_pc), .ex_op_i(ex_op), .ex_funct3_i(ex_funct3), .ex_rd_i(ex_rd),
        .ex_reg_we_i(ex_reg_we), .ex_branch_i(ex_branch),
        .ex_opa_i(ex_opa), .ex_opb_i(ex_opb), .ex_rs2_val_i(ex_rs2_val),
        .ex_rs1_idx_i(ex_rs1_idx), .ex_rs2_idx_i(ex_rs2_idx),
        .ex_opb_is_reg_i(ex_opb_is_reg), .ex_imm_i(ex_imm), .ex_valid_op_i(ex_valid_op),
        .target_o(target), .redirect_o(redirect), .flush_o(flush),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data), .error_o(error_o)
    );

endmodule

// File: verilog/rv_execute.sv
// Execute stage: forwarding, ALU, branch resolution and execute/writeback register
module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_i,
    input  word_t     ex_pc_i,
    input  alu_op_e   ex_op_i,
    input  funct3_t   ex_funct3_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_reg_we_i,
    input  logic      ex_branch_i,
    input  word_t     ex_opa_i,
    input  word_t     ex_opb_i,
    input  word_t     ex_rs2_val_i,
    input  reg_addr_t ex_rs1_idx_i,
    input  reg_addr_t ex_rs2_idx_i,
    input  logic      ex_opb_is_reg_i,
    input  word_t     ex_imm_i,
    input  logic      ex_valid_op_i,
    output word_t     target_o,
    output logic      redirect_o,
    output logic      flush_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      error_o
);

    fwd_sel_e fwd_a, fwd_b;
    word_t    rs1_val, rs2_val;
    word_t    alu_b;
    word_t    alu_res;
    logic     taken;

    // Only the instruction one ahead needs forwarding, older ones come from the regfile
    assign fwd_a = (wb_we_o && wb_rd_o != '0 && wb_rd_o == ex_rs1_idx_i) ? FWD_WB : FWD_REG;
    assign fwd_b = (wb_we_o && wb_rd_o != '0 && wb_rd_o == ex_rs2_idx_i) ? FWD_WB : FWD_REG;

    assign rs1_val = (fwd_a == FWD_WB) ? wb_data_o : ex_opa_i;
    assign rs2_val = (fwd_b == FWD_WB) ? wb_data_o : ex_rs2_val_i;
    assign alu_b   = ex_opb_is_reg_i ? rs2_val : ex_opb_i;

    always_comb begin
        case (ex_op_i)
            ALU_SUB:  alu_res = rs1_val - alu_b;
            ALU_SLL:  alu_res = rs1_val << alu_b[4:0];
            ALU_SLT:  alu_res = word_t'($signed(rs1_val) < $signed(alu_b));
            ALU_SLTU: alu_res = word_t'(rs1_val < alu_b);
            ALU_XOR:  alu_res = rs1_val ^ alu_b;
            ALU_SRL:  alu_res = rs1_val >> alu_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(rs1_val) >>> alu_b[4:0]);
            ALU_OR:   alu_res = rs1_val | alu_b;
            ALU_AND:  alu_res = rs1_val & alu_b;
            default:  alu_res = rs1_val + alu_b;  // ADD, undefined codes too
        endcase
    end

    always_comb begin
        case (branch_cond_e'(ex_funct3_i))
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            BR_GEU:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign target_o   = ex_pc_i + ex_imm_i;
    assign redirect_o = ex_branch_i && taken;
    assign flush_o    = redirect_o;  // Kills fetch/decode and decode/execute

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o <= 1'b0;
            error_o <= 1'b0;
        end else if (!stall_i) begin
            wb_we_o <= ex_reg_we_i;
            if (!ex_valid_op_i) begin
                error_o <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_rd_o   <= ex_rd_i;
            wb_data_o <= alu_res;
        end
    end

    // Decode must have been flushed, so no back-to-back redirect
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o && !stall_i |=> !redirect_o)
        else $error("Redirect right after a taken branch");

endmodule

// File: verilog/rv_fetch.sv
// Fetch stage: program counter and fetch/decode pipeline register
`include "rv_consts.svh"

module rv_fetch
    import rv_pipe_pkg::*;
#(
    parameter word_t RESET_ADDR = `RV_RESET_ADDR
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t target_i,
    input  logic  flush_i,
    input  word_t instr_data_i,
    output word_t instr_addr_o,
    output word_t if_instr_o,
    output word_t if_pc_o
);

    word_t pc;
    word_t pc_next;

    assign pc_next      = redirect_i ? target_i : pc + word_t'(4);
    assign instr_addr_o = pc;  // Memory answers in the same cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= RESET_ADDR;
            if_instr_o <= `RV_NOP;
        end else if (!stall_i) begin
            pc <= pc_next;
            if (flush_i) begin
                if_instr_o <= `RV_NOP;  // Squash wrong-path fetch
            end else begin
                if_instr_o <= instr_data_i;
            end
        end
    end

    // PC of the instruction now in decode
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if_pc_o <= pc;
        end
    end

    // Branch targets from execute must keep the PC aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("PC misaligned: %h", pc);

endmodule
